//--- Bender.yml
package:
  name: armPipe

sources:
  - include_dirs:
      - include
    files:
      - src/armPipePkg.sv
      - src/hazardControl.sv
      - src/instrDecoder.sv
      - src/registerFile.sv
      - src/executeUnit.sv
      - src/stageRegisters.sv
      - src/dataBusMaster.sv
      - src/armPipeTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/clockGen.sv
      - test/armPipe_chk.sv
      - test/armPipeTb.sv

//--- flist.f
+incdir+include
src/armPipePkg.sv
src/hazardControl.sv
src/instrDecoder.sv
src/registerFile.sv
src/executeUnit.sv
src/stageRegisters.sv
src/dataBusMaster.sv
src/armPipeTop.sv
test/clockGen.sv
test/armPipe_chk.sv
test/armPipeTb.sv

//--- include/armPipe_config.svh
`ifndef ARMPIPE_CONFIG_SVH
`define ARMPIPE_CONFIG_SVH

`define ARM_XLEN 32
`define ARM_NREGS 16
`define ARM_RESET_PC 32'h0000_0000
`define ARM_WATCHDOG_CYCLES 4000

`endif

//--- src/armPipePkg.sv
`default_nettype none

`include "armPipe_config.svh"

package armPipePkg;

    typedef enum logic [2:0] {
        OP_AND, OP_SUB, OP_ADD, OP_ORR, OP_MOV, OP_CMP
    } aluOpT;

    // ARM condition field encoding. NV is not supported.
    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL
    } condT;

    typedef struct packed {
        logic  regWrite;
        logic  memToReg;
        logic  memWrite;
        logic  memRead;
        logic  branch;
        logic  aluSrcImm;
        logic  setFlags;
        aluOpT aluOp;
        logic  useRn;
    } ctrlT;

    typedef struct packed {
        logic [`ARM_XLEN-1:0] instr;
        logic [`ARM_XLEN-1:0] pc;
    } fetchDecodeT;

    typedef struct packed {
        ctrlT                 ctrl;
        condT                 cond;
        logic [`ARM_XLEN-1:0] rd1;
        logic [`ARM_XLEN-1:0] rd2;
        logic [`ARM_XLEN-1:0] imm;
        logic [`ARM_XLEN-1:0] pc;
        logic [3:0]           ra1;
        logic [3:0]           ra2;
        logic [3:0]           wa;
    } decodeExecT;

    typedef struct packed {
        ctrlT                 ctrl;
        logic [`ARM_XLEN-1:0] aluResult;
        logic [`ARM_XLEN-1:0] writeData;
        logic [3:0]           wa;
    } execMemT;

    typedef struct packed {
        ctrlT                 ctrl;
        logic [`ARM_XLEN-1:0] readData;
        logic [`ARM_XLEN-1:0] aluOut;
        logic [3:0]           wa;
    } memWbT;

    typedef struct packed {
        logic [`ARM_XLEN-1:0] adr;
        logic [`ARM_XLEN-1:0] dat;
        logic                 we;
    } wbReqT;

endpackage

`default_nettype wire

//--- src/armPipeTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "armPipe_config.svh"

module armPipeTop import armPipePkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    output logic [`ARM_XLEN-1:0] instrAddr,
    input  logic [`ARM_XLEN-1:0] instrData,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    output logic [`ARM_XLEN-1:0] wbAdr,
    output logic [`ARM_XLEN-1:0] wbDatW,
    input  logic [`ARM_XLEN-1:0] wbDatR,
    input  logic                 wbAck
);
    fetchDecodeT fdIn, fdOut;
    decodeExecT  deIn, deOut;
    execMemT     emIn, emOut;
    memWbT       mwIn, mwOut;
    ctrlT        ctrlD, ctrlQ;
    condT        condD;
    logic [3:0]  ra1D, ra2D, waD;
    logic [1:0]  fwdA, fwdB;
    logic [`ARM_XLEN-1:0] pcF, pcNext, immD, rd1D, rd2D, resultW, readDataM;
    logic [`ARM_XLEN-1:0] aluResultE, writeDataE, branchTargetE;
    logic branchTaken, busy, stallF, stallD, flushD, flushE, stallAll;

    assign instrAddr = pcF;
    assign pcNext = branchTaken ? branchTargetE : pcF + 'd4;
    assign fdIn = '{instr: instrData, pc: pcF};
    assign deIn = '{ctrl: ctrlD, cond: condD, rd1: rd1D, rd2: rd2D, imm: immD,
                    pc: fdOut.pc, ra1: ra1D, ra2: ra2D, wa: waD};
    assign emIn = '{ctrl: ctrlQ, aluResult: aluResultE, writeData: writeDataE, wa: deOut.wa};
    assign mwIn = '{ctrl: emOut.ctrl, readData: readDataM, aluOut: emOut.aluResult,
                    wa: emOut.wa};
    assign resultW = mwOut.ctrl.memToReg ? mwOut.readData : mwOut.aluOut;

    hazardControl hazardControl_inst (
        .ra1E(deOut.ra1), .ra2E(deOut.ra2), .waM(emOut.wa), .waW(mwOut.wa),
        .waE(deOut.wa), .ra1D(ra1D), .ra2D(ra2D),
        .ctrlE(deOut.ctrl), .ctrlM(emOut.ctrl), .ctrlW(mwOut.ctrl),
        .branchTaken(branchTaken), .busy(busy), .fwdA(fwdA), .fwdB(fwdB),
        .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
        .stallAll(stallAll)
    );

    instrDecoder instrDecoder_inst (
        .instr(fdOut.instr), .ctrl(ctrlD), .cond(condD), .imm(immD),
        .ra1(ra1D), .ra2(ra2D), .wa(waD)
    );

    registerFile registerFile_inst (
        .clk(clk), .ra1(ra1D), .ra2(ra2D), .rd1(rd1D), .rd2(rd2D),
        .we(mwOut.ctrl.regWrite), .wa(mwOut.wa), .wd(resultW)
    );

    executeUnit executeUnit_inst (
        .clk(clk), .reset(reset), .de(deOut), .fwdA(fwdA), .fwdB(fwdB),
        .fwdM(emOut.aluResult), .fwdW(resultW), .stallAll(stallAll),
        .aluResult(aluResultE), .writeData(writeDataE), .branchTarget(branchTargetE),
        .branchTaken(branchTaken), .ctrlQualified(ctrlQ)
    );

    stageRegisters stageRegisters_inst (
        .clk(clk), .reset(reset), .stallF(stallF), .stallD(stallD), .flushD(flushD),
        .flushE(flushE), .stallAll(stallAll), .pcNext(pcNext), .pcF(pcF),
        .fdIn(fdIn), .fdOut(fdOut), .deIn(deIn), .deOut(deOut),
        .emIn(emIn), .emOut(emOut), .mwIn(mwIn), .mwOut(mwOut)
    );

    dataBusMaster dataBusMaster_inst (
        .clk(clk), .reset(reset), .em(emOut), .readData(readDataM), .busy(busy),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbDatR(wbDatR), .wbAck(wbAck)
    );

endmodule

`default_nettype wire

//--- src/dataBusMaster.sv
`timescale 1ns/1ps
`default_nettype none

`include "armPipe_config.svh"

module dataBusMaster import armPipePkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  execMemT              em,
    output logic [`ARM_XLEN-1:0] readData,
    output logic                 busy,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    output logic [`ARM_XLEN-1:0] wbAdr,
    output logic [`ARM_XLEN-1:0] wbDatW,
    input  logic [`ARM_XLEN-1:0] wbDatR,
    input  logic                 wbAck
);
    // WAIT is the dead cycle after an ack.
    typedef enum logic {IDLE, WAIT} busStateT;

    busStateT state;
    wbReqT    req;
    logic     memOp;

    assign memOp = em.ctrl.memRead || em.ctrl.memWrite;
    assign req = '{adr: em.aluResult, dat: em.writeData, we: em.ctrl.memWrite};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else if (state == WAIT) begin
            state <= IDLE;
        end else if (wbCyc && wbAck) begin
            state <= WAIT;
        end
    end

    // The stage register is frozen while busy, which keeps the request stable.
    assign wbCyc = (state == IDLE) && memOp;
    assign wbStb = wbCyc;
    assign wbWe = req.we;
    assign wbAdr = req.adr;
    assign wbDatW = req.dat;
    assign busy = memOp && !(wbCyc && wbAck);

    // memWb loads on the ack edge, so the slave data goes straight through.
    assign readData = wbDatR;

endmodule

`default_nettype wire

//--- src/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "armPipe_config.svh"

module executeUnit import armPipePkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  decodeExecT           de,
    input  logic [1:0]           fwdA,
    input  logic [1:0]           fwdB,
    input  logic [`ARM_XLEN-1:0] fwdM,
    input  logic [`ARM_XLEN-1:0] fwdW,
    input  logic                 stallAll,
    output logic [`ARM_XLEN-1:0] aluResult,
    output logic [`ARM_XLEN-1:0] writeData,
    output logic [`ARM_XLEN-1:0] branchTarget,
    output logic                 branchTaken,
    output ctrlT                 ctrlQualified
);
    logic [`ARM_XLEN-1:0] srcA, srcB, opB;
    logic [`ARM_XLEN:0]   sum;
    logic [3:0]           flags, newFlags;
    logic                 isSub, condPass, n, z, c, v;

    function automatic logic [`ARM_XLEN-1:0] pickOperand(input logic [1:0] sel,
            input logic [`ARM_XLEN-1:0] regVal, mVal, wVal);
        case (sel)
            2'b10: return mVal;
            2'b01: return wVal;
            default: return regVal;
        endcase
    endfunction

    assign {n, z, c, v} = flags;
    assign srcA = de.ctrl.useRn ? pickOperand(fwdA, de.rd1, fwdM, fwdW) : '0;
    assign writeData = pickOperand(fwdB, de.rd2, fwdM, fwdW);
    assign srcB = de.ctrl.aluSrcImm ? de.imm : writeData;

    // Subtraction as A + ~B + 1, so the carry out is ARM's no-borrow C.
    assign isSub = (de.ctrl.aluOp == OP_SUB) || (de.ctrl.aluOp == OP_CMP);
    assign opB = isSub ? ~srcB : srcB;
    assign sum = {1'b0, srcA} + {1'b0, opB} + isSub;

    always_comb begin
        case (de.ctrl.aluOp)
            OP_AND: aluResult = srcA & srcB;
            OP_ORR: aluResult = srcA | srcB;
            OP_MOV: aluResult = srcB;
            default: aluResult = sum[`ARM_XLEN-1:0];
        endcase
        // Logical ops leave C and V alone.
        newFlags = {aluResult[`ARM_XLEN-1], aluResult == '0, c, v};
        if (de.ctrl.aluOp inside {OP_ADD, OP_SUB, OP_CMP}) begin
            newFlags[1] = sum[`ARM_XLEN];
            newFlags[0] = (srcA[`ARM_XLEN-1] == opB[`ARM_XLEN-1]) &&
                          (sum[`ARM_XLEN-1] != srcA[`ARM_XLEN-1]);
        end
    end

    always_comb begin
        case (de.cond)
            COND_EQ: condPass = z;
            COND_NE: condPass = !z;
            COND_CS: condPass = c;
            COND_CC: condPass = !c;
            COND_MI: condPass = n;
            COND_PL: condPass = !n;
            COND_VS: condPass = v;
            COND_VC: condPass = !v;
            COND_HI: condPass = c && !z;
            COND_LS: condPass = !c || z;
            COND_GE: condPass = (n == v);
            COND_LT: condPass = (n != v);
            COND_GT: condPass = !z && (n == v);
            COND_LE: condPass = z || (n != v);
            COND_AL: condPass = 1'b1;
            default: condPass = 1'b0;
        endcase
    end

    always_comb begin
        ctrlQualified = de.ctrl;
        if (!condPass) begin
            ctrlQualified.regWrite = 1'b0;
            ctrlQualified.memWrite = 1'b0;
            ctrlQualified.memRead = 1'b0;
            ctrlQualified.branch = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (!stallAll && condPass && de.ctrl.setFlags) begin
            flags <= newFlags;
        end
    end

    assign branchTaken = de.ctrl.branch && condPass;
    assign branchTarget = de.pc + 'd8 + de.imm;

endmodule

`default_nettype wire

//--- src/hazardControl.sv
`timescale 1ns/1ps
`default_nettype none

module hazardControl import armPipePkg::*; (
    input  logic [3:0] ra1E,
    input  logic [3:0] ra2E,
    input  logic [3:0] waM,
    input  logic [3:0] waW,
    input  logic [3:0] waE,
    input  logic [3:0] ra1D,
    input  logic [3:0] ra2D,
    input  ctrlT       ctrlE,
    input  ctrlT       ctrlM,
    input  ctrlT       ctrlW,
    input  logic       branchTaken,
    input  logic       busy,
    output logic [1:0] fwdA,
    output logic [1:0] fwdB,
    output logic       stallF,
    output logic       stallD,
    output logic       flushD,
    output logic       flushE,
    output logic       stallAll
);
    logic loadUse;

    // Select 2'b10 takes the memory stage, 2'b01 the writeback stage.
    assign fwdA = (ctrlM.regWrite && waM == ra1E) ? 2'b10 :
                  (ctrlW.regWrite && waW == ra1E) ? 2'b01 : 2'b00;
    assign fwdB = (ctrlM.regWrite && waM == ra2E) ? 2'b10 :
                  (ctrlW.regWrite && waW == ra2E) ? 2'b01 : 2'b00;

    assign loadUse = ctrlE.memRead && (waE == ra1D || waE == ra2D);

    // A taken branch overrides the load-use hold.
    assign stallF = loadUse && !branchTaken;
    assign stallD = loadUse && !branchTaken;
    assign flushD = branchTaken;
    assign flushE = branchTaken || loadUse;
    assign stallAll = busy;

endmodule

`default_nettype wire

//--- src/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "armPipe_config.svh"

module instrDecoder import armPipePkg::*; (
    input  logic [`ARM_XLEN-1:0] instr,
    output ctrlT                 ctrl,
    output condT                 cond,
    output logic [`ARM_XLEN-1:0] imm,
    output logic [3:0]           ra1,
    output logic [3:0]           ra2,
    output logic [3:0]           wa
);
    aluOpT dpOp;
    logic  dpValid;

    assign cond = condT'(instr[31:28]);

    always_comb begin
        dpValid = 1'b1;
        dpOp = OP_AND;
        case (instr[24:21])
            4'b0000: dpOp = OP_AND;
            4'b0010: dpOp = OP_SUB;
            4'b0100: dpOp = OP_ADD;
            4'b1100: dpOp = OP_ORR;
            4'b1101: dpOp = OP_MOV;
            4'b1010: dpOp = OP_CMP;
            default: dpValid = 1'b0;
        endcase
        // CMP needs S, and no shift or rotate amount is allowed.
        if (dpOp == OP_CMP && !instr[20]) dpValid = 1'b0;
        if (instr[25] ? (instr[11:8] != 4'h0) : (instr[11:4] != 8'h00)) dpValid = 1'b0;
    end

    always_comb begin
        ctrl = '0;
        imm = '0;
        ra1 = instr[19:16];
        ra2 = instr[3:0];
        wa = instr[15:12];
        // An all-zero word is a flushed slot.
        if (instr != '0 && instr[31:28] != 4'hF) begin
            if (instr[27:26] == 2'b00 && dpValid) begin
                ctrl.regWrite = (dpOp != OP_CMP);
                ctrl.aluSrcImm = instr[25];
                ctrl.setFlags = instr[20];
                ctrl.aluOp = dpOp;
                ctrl.useRn = (dpOp != OP_MOV);
                imm = {24'h0, instr[7:0]};
            end else if (instr[27:26] == 2'b01 && instr[25:21] == 5'b01100) begin
                ctrl.regWrite = instr[20];
                ctrl.memToReg = instr[20];
                ctrl.memRead = instr[20];
                ctrl.memWrite = !instr[20];
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = OP_ADD;
                ctrl.useRn = 1'b1;
                imm = {20'h0, instr[11:0]};
                if (!instr[20]) ra2 = instr[15:12];
            end else if (instr[27:24] == 4'b1010) begin
                ctrl.branch = 1'b1;
                imm = {{6{instr[23]}}, instr[23:0], 2'b00};
            end
        end
    end

endmodule

`default_nettype wire

//--- src/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "armPipe_config.svh"

module registerFile (
    input  logic                 clk,
    input  logic [3:0]           ra1,
    input  logic [3:0]           ra2,
    output logic [`ARM_XLEN-1:0] rd1,
    output logic [`ARM_XLEN-1:0] rd2,
    input  logic                 we,
    input  logic [3:0]           wa,
    input  logic [`ARM_XLEN-1:0] wd
);
    logic [`ARM_XLEN-1:0] regs [`ARM_NREGS];

    always_ff @(posedge clk) begin
        if (we) regs[wa] <= wd;
    end

    // Writeback and decode share a cycle, so the new value bypasses the array.
    assign rd1 = (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

//--- src/stageRegisters.sv
`timescale 1ns/1ps
`default_nettype none

`include "armPipe_config.svh"

module stageRegisters import armPipePkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stallF,
    input  logic                 stallD,
    input  logic                 flushD,
    input  logic                 flushE,
    input  logic                 stallAll,
    input  logic [`ARM_XLEN-1:0] pcNext,
    output logic [`ARM_XLEN-1:0] pcF,
    input  fetchDecodeT          fdIn,
    output fetchDecodeT          fdOut,
    input  decodeExecT           deIn,
    output decodeExecT           deOut,
    input  execMemT              emIn,
    output execMemT              emOut,
    input  memWbT                mwIn,
    output memWbT                mwOut
);

    // A busy data bus freezes everything, including pending flushes.
    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= `ARM_RESET_PC;
        end else if (!stallAll && !stallF) begin
            pcF <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fdOut <= '0;
        end else if (!stallAll) begin
            if (flushD) begin
                fdOut <= '0;
            end else if (!stallD) begin
                fdOut <= fdIn;
            end
        end
    end

    // Decode to execute only flushes. A load-use stall leaves a bubble here.
    always_ff @(posedge clk) begin
        if (reset) begin
            deOut <= '0;
        end else if (!stallAll) begin
            deOut <= flushE ? '0 : deIn;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            emOut <= '0;
            mwOut <= '0;
        end else if (!stallAll) begin
            emOut <= emIn;
            mwOut <= mwIn;
        end
    end

endmodule

`default_nettype wire

//--- test/armPipeTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "armPipe_config.svh"

module armPipeTb import armPipePkg::*; ();

    localparam logic [3:0] OPC_AND = 4'h0;
    localparam logic [3:0] OPC_SUB = 4'h2;
    localparam logic [3:0] OPC_ADD = 4'h4;
    localparam logic [3:0] OPC_CMP = 4'hA;
    localparam logic [3:0] OPC_ORR = 4'hC;
    localparam logic [3:0] OPC_MOV = 4'hD;

    logic clk, reset, resetReq;
    logic [`ARM_XLEN-1:0] instrAddr, instrData, wbAdr, wbDatW, wbDatR;
    logic wbCyc, wbStb, wbWe, wbAck;

    logic [`ARM_XLEN-1:0] rom [256];
    logic [`ARM_XLEN-1:0] dataMem [256];
    logic [`ARM_XLEN-1:0] prog [$];
    wbReqT storeLog [$];
    wbReqT expStores [$];
    logic randomWaits, reqActive;
    int waitLeft, wordIdx;

    clockGen clockGen_inst (.resetReq(resetReq), .clk(clk), .reset(reset));

    armPipeTop armPipeTop_inst (
        .clk(clk), .reset(reset), .instrAddr(instrAddr), .instrData(instrData),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbDatR(wbDatR), .wbAck(wbAck)
    );

    bind armPipeTop armPipe_chk armPipe_chk_inst (
        .clk(clk), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAck(wbAck), .wbAdr(wbAdr), .wbDatW(wbDatW), .instrAddr(instrAddr),
        .stallAll(stallAll), .stallF(stallF)
    );

    assign instrData = rom[instrAddr[9:2]];

    // Wishbone slave. Ack comes with the request, so zero wait states are legal.
    always @(negedge clk) begin
        if (wbCyc && wbStb) begin
            if (!reqActive) begin
                reqActive = 1'b1;
                waitLeft = randomWaits ? int'($urandom % 4) : 0;
            end
            if (waitLeft == 0) begin
                wordIdx = int'(wbAdr[9:2]);
                if (wbWe) begin
                    dataMem[wordIdx] = wbDatW;
                    storeLog.push_back('{adr: wbAdr, dat: wbDatW, we: wbWe});
                end
                wbDatR <= dataMem[wordIdx];
                wbAck <= 1'b1;
            end else begin
                waitLeft = waitLeft - 1;
                wbAck <= 1'b0;
            end
        end else begin
            reqActive = 1'b0;
            wbAck <= 1'b0;
        end
    end

    function automatic logic [31:0] dpImm(input condT c, input logic [3:0] opc,
            input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [7:0] imm8);
        return {c, 3'b001, opc, s, rn, rd, 4'h0, imm8};
    endfunction

    function automatic logic [31:0] dpReg(input condT c, input logic [3:0] opc,
            input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rm);
        return {c, 3'b000, opc, s, rn, rd, 8'h00, rm};
    endfunction

    // Pre-indexed, positive offset, word access, no writeback.
    function automatic logic [31:0] memOp(input condT c, input logic load,
            input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] off);
        return {c, 3'b010, 4'b1100, load, rn, rd, off};
    endfunction

    function automatic logic [31:0] branchTo(input condT c, input int src, input int dst);
        return {c, 4'b1010, 24'(dst - src - 2)};
    endfunction

    function automatic logic [31:0] fillWord(input int idx);
        return 32'hC0DE_0000 | 32'(idx << 2);
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic expectStore(input logic [31:0] a, input logic [31:0] d);
        expStores.push_back('{adr: a, dat: d, we: 1'b1});
    endtask

    task automatic newProgram();
        prog.delete();
        expStores.delete();
        emit(dpImm(COND_AL, OPC_MOV, 1'b0, 4'd0, 4'd0, 8'h00));
    endtask

    task automatic stopOnError(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) stopOnError($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) stopOnError($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic checkStore(input wbReqT got, input wbReqT exp, input string what);
        if (got !== exp) begin
            stopOnError($sformatf("%s: got adr %h dat %h we %b, expected adr %h dat %h we %b",
                what, got.adr, got.dat, got.we, exp.adr, exp.dat, exp.we));
        end
    endtask

    // Holds the core in reset while the ROM and data memory are reloaded.
    task automatic runProgram(input logic randomMode);
        @(negedge clk);
        resetReq <= 1'b1;
        @(negedge clk);
        resetReq <= 1'b0;
        @(negedge clk);
        foreach (rom[i]) rom[i] = (i < prog.size()) ? prog[i] : '0;
        foreach (dataMem[i]) dataMem[i] = fillWord(i);
        storeLog.delete();
        randomWaits = randomMode;
        checkBit(wbCyc, 1'b0, "wbCyc in reset");
        checkBit(wbStb, 1'b0, "wbStb in reset");
        checkWord(instrAddr, `ARM_RESET_PC, "instrAddr in reset");
        while (reset) @(negedge clk);
        while (storeLog.size() < expStores.size()) @(posedge clk);
        // Let the final loop spin so that any extra store shows up.
        repeat (24) @(posedge clk);
        checkWord(32'(storeLog.size()), 32'(expStores.size()), "number of stores");
        foreach (expStores[i]) checkStore(storeLog[i], expStores[i], $sformatf("store %0d", i));
    endtask

    task automatic testAluOps(input logic randomMode);
        newProgram();
        emit(dpImm(COND_AL, OPC_MOV, 1'b0, 4'd0, 4'd1, 8'h5A));
        emit(dpImm(COND_AL, OPC_MOV, 1'b0, 4'd0, 4'd2, 8'h0F));
        emit(dpReg(COND_AL, OPC_AND, 1'b0, 4'd1, 4'd3, 4'd2));
        emit(dpImm(COND_AL, OPC_ORR, 1'b0, 4'd1, 4'd4, 8'h30));
        emit(dpReg(COND_AL, OPC_ADD, 1'b0, 4'd1, 4'd5, 4'd2));
        emit(dpReg(COND_AL, OPC_SUB, 1'b0, 4'd2, 4'd6, 4'd1));
        emit(dpReg(COND_AL, OPC_MOV, 1'b0, 4'd0, 4'd7, 4'd2));
        for (int r = 3; r <= 7; r++) emit(memOp(COND_AL, 1'b0, 4'd0, 4'(r), 12'(r * 4 + 'h0F4)));
        emit(branchTo(COND_AL, prog.size(), prog.size()));
        expectStore(32'h100, 32'h5A & 32'h0F);
        expectStore(32'h104, 32'h5A | 32'h30);
        expectStore(32'h108, 32'h5A + 32'h0F);
        expectStore(32'h10C, 32'h0F - 32'h5A);
        expectStore(32'h110, 32'h0F);
        runProgram(randomMode);
    endtask

    task automatic testForwarding(input logic randomMode);
        newProgram();
        emit(dpImm(COND_AL, OPC_MOV, 1'b0, 4'd0, 4'd1, 8'd3));
        emit(dpImm(COND_AL, OPC_ADD, 1'b0, 4'd1, 4'd2, 8'd4));
        emit(dpReg(COND_AL, OPC_ADD, 1'b0, 4'd2, 4'd3, 4'd1));
        emit(dpReg(COND_AL, OPC_SUB, 1'b0, 4'd3, 4'd4, 4'd2));
        emit(dpReg(COND_AL, OPC_ORR, 1'b0, 4'd4, 4'd5, 4'd3));
        emit(memOp(COND_AL, 1'b0, 4'd0, 4'd5, 12'h120));
        emit(memOp(COND_AL, 1'b0, 4'd0, 4'd4, 12'h124));
        emit(dpReg(COND_AL, OPC_AND, 1'b0, 4'd5, 4'd6, 4'd3));
        emit(memOp(COND_AL, 1'b0, 4'd0, 4'd6, 12'h128));
        emit(branchTo(COND_AL, prog.size(), prog.size()));
        // r1 = 3, r2 = 7, r3 = 10, r4 = 3, r5 = 11, r6 = 10.
        expectStore(32'h120, 32'd11);
        expectStore(32'h124, 32'd3);
        expectStore(32'h128, 32'd10);
        runProgram(randomMode);
    endtask

    task automatic testLoadUse(input logic randomMode);
        newProgram();
        emit(memOp(COND_AL, 1'b1, 4'd0, 4'd1, 12'h200));
        emit(dpImm(COND_AL, OPC_ADD, 1'b0, 4'd1, 4'd2, 8'd1));
        emit(memOp(COND_AL, 1'b0, 4'd0, 4'd2, 12'h130));
        emit(memOp(COND_AL, 1'b1, 4'd0, 4'd3, 12'h204));
        emit(memOp(COND_AL, 1'b0, 4'd0, 4'd3, 12'h134));
        emit(memOp(COND_AL, 1'b1, 4'd0, 4'd4, 12'h130));
        emit(dpReg(COND_AL, OPC_ORR, 1'b0, 4'd4, 4'd5, 4'd4));
        emit(memOp(COND_AL, 1'b0, 4'd0, 4'd5, 12'h138));
        emit(branchTo(COND_AL, prog.size(), prog.size()));
        expectStore(32'h130, fillWord('h200 >> 2) + 32'd1);
        expectStore(32'h134, fillWord('h204 >> 2));
        expectStore(32'h138, fillWord('h200 >> 2) + 32'd1);
        runProgram(randomMode);
    endtask

    task automatic testConditional(input logic randomMode);
        newProgram();
        emit(dpImm(COND_AL, OPC_MOV, 1'b0, 4'd0, 4'd1, 8'd5));
        emit(dpImm(COND_AL, OPC_CMP, 1'b1, 4'd1, 4'd0, 8'd5));
        emit(memOp(COND_NE, 1'b0, 4'd0, 4'd1, 12'h140));
        emit(dpImm(COND_EQ, OPC_MOV, 1'b0, 4'd0, 4'd2, 8'h11));
        emit(memOp(COND_EQ, 1'b0, 4'd0, 4'd2, 12'h144));
        emit(branchTo(COND_NE, 6, 8));
        emit(memOp(COND_AL, 1'b0, 4'd0, 4'd1, 12'h148));
        // 5 - 9 gives N set and V clear, so LT holds.
        emit(dpImm(COND_AL, OPC_CMP, 1'b1, 4'd1, 4'd0, 8'd9));
        emit(branchTo(COND_LT, 9, 12));
        emit(memOp(COND_AL, 1'b0, 4'd0, 4'd1, 12'h14C));
        emit(memOp(COND_AL, 1'b0, 4'd0, 4'd1, 12'h150));
        emit(dpImm(COND_GE, OPC_ADD, 1'b0, 4'd1, 4'd3, 8'd1));
        emit(dpImm(COND_LT, OPC_ADD, 1'b0, 4'd1, 4'd3, 8'd2));
        emit(memOp(COND_AL, 1'b0, 4'd0, 4'd3, 12'h154));
        emit(branchTo(COND_AL, prog.size(), prog.size()));
        expectStore(32'h144, 32'h11);
        expectStore(32'h148, 32'd5);
        expectStore(32'h154, 32'd7);
        runProgram(randomMode);
    endtask

    // Same programs and expected stores, now with 0 to 3 wait states per access.
    task automatic testRandomWaits();
        testAluOps(1'b1);
        testForwarding(1'b1);
        testLoadUse(1'b1);
        testConditional(1'b1);
    endtask

    initial begin
        repeat (`ARM_WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: the tests did not finish in %0d cycles.",
            `ARM_WATCHDOG_CYCLES);
        $display("** FAIL **");
        $fatal(1, "Watchdog timeout.");
    end

    initial begin
        resetReq = 1'b0;
        wbAck = 1'b0;
        wbDatR = '0;
        randomWaits = 1'b0;
        reqActive = 1'b0;
        waitLeft = 0;
        foreach (rom[i]) rom[i] = '0;
        void'($urandom(53522));
        testAluOps(1'b0);
        testForwarding(1'b0);
        testLoadUse(1'b0);
        testConditional(1'b0);
        testRandomWaits();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/armPipe_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "armPipe_config.svh"

module armPipe_chk (
    input logic                 clk,
    input logic                 reset,
    input logic                 wbCyc,
    input logic                 wbStb,
    input logic                 wbWe,
    input logic                 wbAck,
    input logic [`ARM_XLEN-1:0] wbAdr,
    input logic [`ARM_XLEN-1:0] wbDatW,
    input logic [`ARM_XLEN-1:0] instrAddr,
    input logic                 stallAll,
    input logic                 stallF
);

    stbNeedsCyc: assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc)
        else $error("wbStb is high without wbCyc");

    // A request without ack must come back unchanged on the next edge.
    requestStable: assert property (@(posedge clk) disable iff (reset)
        (wbCyc && wbStb && !wbAck) |=>
        (wbCyc && wbStb && $stable({wbWe, wbAdr, wbDatW})))
        else $error("Wishbone request changed before ack");

    cycDropsAfterAck: assert property (@(posedge clk) disable iff (reset)
        (wbCyc && wbAck) |=> !wbCyc)
        else $error("wbCyc still high one cycle after ack");

    fetchHolds: assert property (@(posedge clk) disable iff (reset)
        (stallAll || stallF) |=> $stable(instrAddr))
        else $error("instrAddr moved during a stall");

endmodule

`default_nettype wire

//--- test/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    input  logic resetReq,
    output logic clk,
    output logic reset
);
    int holdLeft = 16;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Reset moves on the falling edge and spans 16 rising edges.
    always @(negedge clk) begin
        if (resetReq) begin
            holdLeft <= 16;
        end else if (holdLeft != 0) begin
            holdLeft <= holdLeft - 1;
        end
    end

    assign reset = (holdLeft != 0);

endmodule

`default_nettype wire
